// File: src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN    = 32;
    localparam int SHAMT_W = $clog2(XLEN);       // serial shift counter width

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011
    } opcode_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;  // addi has no sub form
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra, srai

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // one word, two views; opcode picks the one that means something
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

`default_nettype wire

// File: src/backend_pkg.sv
`default_nettype none

package backend_pkg;

    import rv_isa_pkg::*;

    localparam int NUM_LANES = 3;
    localparam int ROB_DEPTH = 8;
    localparam int ROB_ID_W  = $clog2(ROB_DEPTH);
    localparam int LREG_W    = 5;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA, NOP
    } alu_op_e;

    typedef struct packed {
        logic [ROB_ID_W-1:0] robid;
        alu_op_e             alu_op;
        logic [XLEN-1:0]     src1;
        logic [XLEN-1:0]     src2;  // rs2 value or sign-extended imm
    } uop_t;

    typedef struct packed {
        logic                valid;
        logic [ROB_ID_W-1:0] robid;
        logic [XLEN-1:0]     result;
    } wb_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [LREG_W-1:0] lrd;
        logic              need_to_wb;
    } rob_alloc_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [LREG_W-1:0] lrd;
        logic              need_to_wb;
        logic [XLEN-1:0]   result;
    } commit_t;

endpackage

`default_nettype wire

// File: src/arch_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module arch_regfile
    import rv_isa_pkg::*, backend_pkg::*;
(
    input  logic              clock,
    input  logic              rst,
    input  logic [LREG_W-1:0] rs1_addr,
    input  logic [LREG_W-1:0] rs2_addr,
    output logic [XLEN-1:0]   rs1_data,
    output logic [XLEN-1:0]   rs2_data,
    input  commit_t           commit
);

    logic [XLEN-1:0] regs_q [2**LREG_W];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < 2**LREG_W; i++) begin
                regs_q[i] <= '0;
            end
        end else if (commit.valid && commit.need_to_wb && commit.lrd != '0) begin
            regs_q[commit.lrd] <= commit.result;
        end
    end

    // async read, x0 hardwired
    assign rs1_data = (rs1_addr == '0) ? '0 : regs_q[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs_q[rs2_addr];

endmodule

`default_nettype wire

// File: src/alu_lane.sv
`timescale 1ns/1ps
`default_nettype none

module alu_lane
    import rv_isa_pkg::*, backend_pkg::*;
(
    input  logic clock,
    input  logic rst,
    input  logic issue_valid,
    input  uop_t issue_uop,
    output logic busy,
    output wb_t  wb
);

    logic                is_shift;
    logic                long_shift;
    logic [XLEN-1:0]     alu_out;
    logic [XLEN-1:0]     shift_next;
    logic                shifting_q;
    logic                wb_valid_q;
    alu_op_e             shift_op_q;
    logic [SHAMT_W-1:0]  shift_cnt_q;
    logic [ROB_ID_W-1:0] robid_q;
    logic [XLEN-1:0]     result_q;   // alu result or shift working reg

    assign is_shift   = issue_uop.alu_op inside {SLL, SRL, SRA};
    assign long_shift = is_shift && (issue_uop.src2[SHAMT_W-1:0] != '0);

    always_comb begin
        case (issue_uop.alu_op)
            ADD:     alu_out = issue_uop.src1 + issue_uop.src2;
            SUB:     alu_out = issue_uop.src1 - issue_uop.src2;
            AND:     alu_out = issue_uop.src1 & issue_uop.src2;
            OR:      alu_out = issue_uop.src1 | issue_uop.src2;
            XOR:     alu_out = issue_uop.src1 ^ issue_uop.src2;
            SLT:     alu_out = {{(XLEN-1){1'b0}},
                                $signed(issue_uop.src1) < $signed(issue_uop.src2)};
            SLTU:    alu_out = {{(XLEN-1){1'b0}}, issue_uop.src1 < issue_uop.src2};
            default: alu_out = '0;  // nop
        endcase
    end

    always_comb begin
        case (shift_op_q)
            SLL:     shift_next = {result_q[XLEN-2:0], 1'b0};
            SRA:     shift_next = {result_q[XLEN-1], result_q[XLEN-1:1]};
            default: shift_next = {1'b0, result_q[XLEN-1:1]};
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            shifting_q <= 1'b0;
            wb_valid_q <= 1'b0;
        end else if (issue_valid) begin
            shifting_q <= long_shift;
            wb_valid_q <= !long_shift;  // shift by 0 behaves like single cycle op
        end else begin
            shifting_q <= shifting_q && (shift_cnt_q != SHAMT_W'(1));
            wb_valid_q <= shifting_q && (shift_cnt_q == SHAMT_W'(1));
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            robid_q     <= issue_uop.robid;
            shift_op_q  <= issue_uop.alu_op;
            shift_cnt_q <= issue_uop.src2[SHAMT_W-1:0];
            result_q    <= is_shift ? issue_uop.src1 : alu_out;
        end else if (shifting_q) begin
            shift_cnt_q <= shift_cnt_q - 1'b1;
            result_q    <= shift_next;  // one bit per cycle
        end
    end

    assign busy = shifting_q;
    assign wb   = '{valid: wb_valid_q, robid: robid_q, result: result_q};

    a_no_issue_busy : assert property (@(posedge clock) disable iff (rst)
        busy |-> !issue_valid);

endmodule

`default_nettype wire

// File: src/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer
    import rv_isa_pkg::*, backend_pkg::*;
(
    input  logic                clock,
    input  logic                rst,
    input  rob_alloc_t          alloc,
    output logic [ROB_ID_W-1:0] alloc_robid,
    output logic                rob_full,
    input  wb_t                 lane_wb [NUM_LANES],
    output commit_t             commit
);

    logic [ROB_ID_W:0]    head_q;     // extra msb tells full from empty
    logic [ROB_ID_W:0]    tail_q;
    logic [ROB_ID_W:0]    count;
    logic [ROB_ID_W-1:0]  head_idx;
    logic [ROB_DEPTH-1:0] done_q;
    logic [ROB_DEPTH-1:0] occupied;
    logic                 retire;
    logic [XLEN-1:0]      pc_q       [ROB_DEPTH];
    logic [LREG_W-1:0]    lrd_q      [ROB_DEPTH];
    logic                 need_wb_q  [ROB_DEPTH];
    logic [XLEN-1:0]      result_q   [ROB_DEPTH];
    logic                 commit_valid_q;
    logic [XLEN-1:0]      commit_pc_q;
    logic [LREG_W-1:0]    commit_lrd_q;
    logic                 commit_need_q;
    logic [XLEN-1:0]      commit_result_q;

    assign head_idx    = head_q[ROB_ID_W-1:0];
    assign alloc_robid = tail_q[ROB_ID_W-1:0];
    assign count       = tail_q - head_q;
    assign rob_full    = (count == (ROB_ID_W+1)'(ROB_DEPTH));
    assign retire      = (count != '0) && done_q[head_idx];

    always_comb begin
        logic [ROB_ID_W-1:0] offs;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            offs        = ROB_ID_W'(i) - head_idx;
            occupied[i] = ({1'b0, offs} < count);
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            head_q         <= '0;
            tail_q         <= '0;
            done_q         <= '0;
            commit_valid_q <= 1'b0;
        end else begin
            commit_valid_q <= retire;
            if (retire) begin
                head_q <= head_q + 1'b1;
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                if (lane_wb[l].valid) begin
                    done_q[lane_wb[l].robid] <= 1'b1;
                end
            end
            if (alloc.valid) begin
                done_q[alloc_robid] <= 1'b0;
                tail_q              <= tail_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc.valid) begin
            pc_q[alloc_robid]      <= alloc.pc;
            lrd_q[alloc_robid]     <= alloc.lrd;
            need_wb_q[alloc_robid] <= alloc.need_to_wb;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            if (lane_wb[l].valid) begin
                result_q[lane_wb[l].robid] <= lane_wb[l].result;
            end
        end
        if (retire) begin
            commit_pc_q     <= pc_q[head_idx];
            commit_lrd_q    <= lrd_q[head_idx];
            commit_need_q   <= need_wb_q[head_idx];
            commit_result_q <= result_q[head_idx];
        end
    end

    assign commit = '{valid:      commit_valid_q,
                      pc:         commit_pc_q,
                      lrd:        commit_lrd_q,
                      need_to_wb: commit_need_q,
                      result:     commit_result_q};

    a_no_alloc_full : assert property (@(posedge clock) disable iff (rst)
        alloc.valid |-> !rob_full);

    for (genvar a = 0; a < NUM_LANES; a++) begin : g_wb_chk
        a_wb_live : assert property (@(posedge clock) disable iff (rst)
            lane_wb[a].valid |-> occupied[lane_wb[a].robid] && !done_q[lane_wb[a].robid]);
        for (genvar b = a + 1; b < NUM_LANES; b++) begin : g_pair
            a_wb_unique : assert property (@(posedge clock) disable iff (rst)
                !(lane_wb[a].valid && lane_wb[b].valid &&
                  lane_wb[a].robid == lane_wb[b].robid));
        end
    end

endmodule

`default_nettype wire

// File: src/instr_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module instr_dispatch
    import rv_isa_pkg::*, backend_pkg::*;
(
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 instr_valid,
    output logic                 instr_ready,
    input  instr_u               instr,
    input  logic [XLEN-1:0]      pc,
    output logic [LREG_W-1:0]    rs1_addr,
    output logic [LREG_W-1:0]    rs2_addr,
    input  logic [XLEN-1:0]      rs1_data,
    input  logic [XLEN-1:0]      rs2_data,
    input  logic [NUM_LANES-1:0] lane_busy,
    output logic [NUM_LANES-1:0] issue_valid,
    output uop_t                 issue_uop,
    output rob_alloc_t           alloc,
    input  logic [ROB_ID_W-1:0]  alloc_robid,
    input  logic                 rob_full,
    input  commit_t              commit
);

    logic [2**LREG_W-1:0]  busy_q;    // scoreboard, one bit per arch reg
    alu_op_e               dec_op;
    logic                  legal;
    logic                  use_imm;
    logic                  need_to_wb;
    logic [XLEN-1:0]       imm_ext;
    logic                  src_busy;
    logic                  rd_busy;
    logic [NUM_LANES-1:0]  lane_sel;
    logic                  lane_found;
    logic                  accept;

    function automatic alu_op_e f3_to_op(input logic [2:0] funct3, input logic alt);
        case (funct3)
            F3_ADD_SUB: return alt ? SUB : ADD;
            F3_SLL:     return SLL;
            F3_SLT:     return SLT;
            F3_SLTU:    return SLTU;
            F3_XOR:     return XOR;
            F3_SRL_SRA: return alt ? SRA : SRL;
            F3_OR:      return OR;
            F3_AND:     return AND;
            default:    return NOP;
        endcase
    endfunction

    assign imm_ext = {{(XLEN-12){instr.i.imm[11]}}, instr.i.imm};

    always_comb begin
        dec_op  = NOP;
        legal   = 1'b0;
        use_imm = 1'b0;
        case (instr.r.opcode)
            OP: begin
                legal  = (instr.r.funct7 == F7_BASE) ||
                         (instr.r.funct7 == F7_ALT &&
                          (instr.r.funct3 == F3_ADD_SUB || instr.r.funct3 == F3_SRL_SRA));
                dec_op = f3_to_op(instr.r.funct3, instr.r.funct7 == F7_ALT);
            end
            OP_IMM: begin
                use_imm = 1'b1;
                // shamt forms reuse the funct7 slot of the r view
                if (instr.r.funct3 == F3_SLL) begin
                    legal = (instr.r.funct7 == F7_BASE);
                end else if (instr.r.funct3 == F3_SRL_SRA) begin
                    legal = (instr.r.funct7 == F7_BASE) || (instr.r.funct7 == F7_ALT);
                end else begin
                    legal = 1'b1;
                end
                dec_op = f3_to_op(instr.r.funct3,
                                  instr.r.funct3 == F3_SRL_SRA && instr.r.funct7 == F7_ALT);
            end
            default: legal = 1'b0;
        endcase
    end

    assign need_to_wb = legal && (instr.r.rd != '0);
    assign rs1_addr   = instr.r.rs1;
    assign rs2_addr   = instr.r.rs2;
    assign src_busy   = legal && (busy_q[instr.r.rs1] || (!use_imm && busy_q[instr.r.rs2]));
    assign rd_busy    = need_to_wb && busy_q[instr.r.rd];

    always_comb begin
        lane_sel   = '0;
        lane_found = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (!lane_busy[i] && !lane_found) begin  // lowest free lane wins
                lane_sel[i] = 1'b1;
                lane_found  = 1'b1;
            end
        end
    end

    assign instr_ready = lane_found && !rob_full && !src_busy && !rd_busy;
    assign accept      = instr_valid && instr_ready;
    assign issue_valid = accept ? lane_sel : '0;

    assign issue_uop = '{robid:  alloc_robid,
                         alu_op: legal ? dec_op : NOP,
                         src1:   rs1_data,
                         src2:   use_imm ? imm_ext : rs2_data};

    assign alloc = '{valid: accept, pc: pc, lrd: instr.r.rd, need_to_wb: need_to_wb};

    always_ff @(posedge clock) begin
        if (rst) begin
            busy_q <= '0;
        end else begin
            if (commit.valid && commit.need_to_wb) begin
                busy_q[commit.lrd] <= 1'b0;
            end
            if (accept && need_to_wb) begin
                busy_q[instr.r.rd] <= 1'b1;
            end
        end
    end

    a_hold_stable : assert property (@(posedge clock) disable iff (rst)
        instr_valid && !instr_ready |=> $stable(instr) && $stable(pc));

endmodule

`default_nettype wire

// File: src/backend_top.sv
`timescale 1ns/1ps
`default_nettype none

module backend_top
    import rv_isa_pkg::*, backend_pkg::*;
(
    input  logic        clock,
    input  logic        rst,
    input  logic        instr_valid,
    output logic        instr_ready,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    output commit_t     commit
);

    logic [LREG_W-1:0]    rs1_addr;
    logic [LREG_W-1:0]    rs2_addr;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;
    logic [NUM_LANES-1:0] lane_busy;
    logic [NUM_LANES-1:0] issue_valid;
    uop_t                 issue_uop;
    rob_alloc_t           alloc;
    logic [ROB_ID_W-1:0]  alloc_robid;
    logic                 rob_full;
    wb_t                  lane_wb [NUM_LANES];

    instr_dispatch u_instr_dispatch (
        .clock       (clock),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .pc          (pc),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .lane_busy   (lane_busy),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop),   // shared by all lanes
        .alloc       (alloc),
        .alloc_robid (alloc_robid),
        .rob_full    (rob_full),
        .commit      (commit)
    );

    arch_regfile u_arch_regfile (
        .clock    (clock),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .commit   (commit)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        alu_lane u_alu_lane (
            .clock       (clock),
            .rst         (rst),
            .issue_valid (issue_valid[g]),
            .issue_uop   (issue_uop),
            .busy        (lane_busy[g]),
            .wb          (lane_wb[g])
        );
    end

    reorder_buffer u_reorder_buffer (
        .clock       (clock),
        .rst         (rst),
        .alloc       (alloc),
        .alloc_robid (alloc_robid),
        .rob_full    (rob_full),
        .lane_wb     (lane_wb),
        .commit      (commit)
    );

endmodule

`default_nettype wire

// File: sim/backend_tb_table.svh
`ifndef BACKEND_TB_TABLE_SVH
`define BACKEND_TB_TABLE_SVH

// columns: instruction word, expected lrd, expected need_to_wb, expected result
// entry n is sent with pc = n*4 and must commit in table order

localparam int NUM_VECTORS = 28;

function automatic vector_t table_entry(input int idx);
    case (idx)
        0:  return {32'h06400093, 5'd1,  1'b1, 32'h00000064};  // addi x1, x0, 100
        1:  return {32'hFF900113, 5'd2,  1'b1, 32'hFFFFFFF9};  // addi x2, x0, -7
        2:  return {32'h002081B3, 5'd3,  1'b1, 32'h0000005D};  // add x3, x1, x2
        3:  return {32'h40208233, 5'd4,  1'b1, 32'h0000006B};  // sub x4, x1, x2
        4:  return {32'h001122B3, 5'd5,  1'b1, 32'h00000001};  // slt x5, x2, x1
        5:  return {32'h00113333, 5'd6,  1'b1, 32'h00000000};  // sltu x6, x2, x1
        6:  return {32'hFFF12393, 5'd7,  1'b1, 32'h00000001};  // slti x7, x2, -1
        7:  return {32'hFFF0B413, 5'd8,  1'b1, 32'h00000001};  // sltiu x8, x1, -1
        8:  return {32'hFFF0C493, 5'd9,  1'b1, 32'hFFFFFF9B};  // xori x9, x1, -1
        9:  return {32'h0F017513, 5'd10, 1'b1, 32'h000000F0};  // andi x10, x2, 0xf0
        10: return {32'h7000E593, 5'd11, 1'b1, 32'h00000764};  // ori x11, x1, 0x700
        11: return {32'h0020F633, 5'd12, 1'b1, 32'h00000060};  // and x12, x1, x2
        12: return {32'h0020E6B3, 5'd13, 1'b1, 32'hFFFFFFFD};  // or x13, x1, x2
        13: return {32'h0020C733, 5'd14, 1'b1, 32'hFFFFFF9D};  // xor x14, x1, x2
        14: return {32'h41F15793, 5'd15, 1'b1, 32'hFFFFFFFF};  // srai x15, x2, 31
        15: return {32'h00108813, 5'd16, 1'b1, 32'h00000065};  // addi x16, x1, 1
        16: return {32'h01409893, 5'd17, 1'b1, 32'h06400000};  // slli x17, x1, 20
        17: return {32'h01C15913, 5'd18, 1'b1, 32'h0000000F};  // srli x18, x2, 28
        18: return {32'h401809B3, 5'd19, 1'b1, 32'h00000001};  // sub x19, x16, x1
        19: return {32'h01178A33, 5'd20, 1'b1, 32'h063FFFFF};  // add x20, x15, x17
        20: return {32'h01009AB3, 5'd21, 1'b1, 32'h00000C80};  // sll x21, x1, x16
        21: return {32'h00115B33, 5'd22, 1'b1, 32'h0FFFFFFF};  // srl x22, x2, x1
        22: return {32'h4014DBB3, 5'd23, 1'b1, 32'hFFFFFFF9};  // sra x23, x9, x1
        23: return {32'h00508013, 5'd0,  1'b0, 32'h00000069};  // addi x0, x1, 5
        24: return {32'h00100C33, 5'd24, 1'b1, 32'h00000064};  // add x24, x0, x1
        25: return {32'h00012083, 5'd1,  1'b0, 32'h00000000};  // lw, not supported
        26: return {32'h02108CB3, 5'd25, 1'b0, 32'h00000000};  // mul, not supported
        27: return {32'h00008D13, 5'd26, 1'b1, 32'h00000064};  // x1 left untouched
        default: return '0;
    endcase
endfunction

`endif

// File: sim/backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module backend_tb
    import rv_isa_pkg::*, backend_pkg::*;
();

    typedef struct packed {
        logic [31:0]       word;
        logic [LREG_W-1:0] lrd;
        logic              need_to_wb;
        logic [31:0]       result;
    } vector_t;

    `include "backend_tb_table.svh"

    logic        clock = 1'b0;
    logic        rst;
    logic        instr_valid;
    logic        instr_ready;
    logic [31:0] instr;
    logic [31:0] pc;
    commit_t     commit;

    integer      seed = 39;
    int          errors;
    int          commit_count;

    backend_top dut_i (
        .clock       (clock),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .pc          (pc),
        .commit      (commit)
    );

    initial begin
        forever #2 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    // runs from a rising edge to the edge that accepts
    task automatic send_instr(input logic [31:0] word, input logic [31:0] addr);
        instr_valid <= 1'b1;
        instr       <= word;
        pc          <= addr;
        @(negedge clock);
        while (!instr_ready) begin
            @(negedge clock);  // held while stalled
        end
        @(posedge clock);
    endtask

    always @(negedge clock) begin : commit_monitor
        vector_t expected;
        if (rst) begin
            check_value("commit.valid", commit.valid, 32'd0);
            check_value("instr_ready", 32'(instr_ready), 32'd1);  // lanes, rob, scoreboard idle
        end else if (commit.valid) begin
            if (commit_count >= NUM_VECTORS) begin
                $display("Error at %0t: extra commit after all %0d entries committed",
                         $time, NUM_VECTORS);
                errors++;
            end else begin
                expected = table_entry(commit_count);
                check_value("commit.pc", commit.pc, 32'(commit_count * 4));
                check_value("commit.lrd", 32'(commit.lrd), 32'(expected.lrd));
                check_value("commit.need_to_wb", 32'(commit.need_to_wb),
                            32'(expected.need_to_wb));
                check_value("commit.result", commit.result, expected.result);
            end
            commit_count++;
        end
    end

    initial begin : stimulus
        int      idle;
        vector_t entry;
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        pc           = '0;
        errors       = 0;
        commit_count = 0;
        repeat (3) @(posedge clock);
        rst <= 1'b0;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            entry = table_entry(i);
            send_instr(entry.word, 32'(i * 4));
            idle = $random(seed) & 3;
            if (idle != 0) begin
                instr_valid <= 1'b0;
                repeat (idle) @(posedge clock);
            end
        end
        instr_valid <= 1'b0;
        wait (commit_count == NUM_VECTORS);
        repeat (10) @(posedge clock);  // room for a stray extra commit
        check_value("commit count", 32'(commit_count), 32'(NUM_VECTORS));
        $display("Summary: %0d errors, %0d of %0d commits seen",
                 errors, commit_count, NUM_VECTORS);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin : watchdog
        @(negedge rst);
        repeat (NUM_VECTORS * 40) @(posedge clock);
        $display("Timeout: commits are missing, only %0d of %0d arrived in time",
                 commit_count, NUM_VECTORS);
        errors++;
        $display("Summary: %0d errors, %0d of %0d commits seen",
                 errors, commit_count, NUM_VECTORS);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+sim
src/rv_isa_pkg.sv
src/backend_pkg.sv
src/arch_regfile.sv
src/alu_lane.sv
src/reorder_buffer.sv
src/instr_dispatch.sv
src/backend_top.sv
sim/backend_tb.sv
